// File: flist.f
sum_kernel_pkg.sv
result_stream_if.sv
sync_fifo.sv
vertex_sum_accumulator.sv
sum_kernel_regs.sv
sum_kernel_cu.sv
sum_kernel_checker.sv
sum_kernel_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the sum kernel testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module sum_kernel_tb \
	-f flist.f -o sum_kernel_sim
./obj_dir/sum_kernel_sim +verilator+error+limit+100 | tee sim.log
if grep -qx "sim passed" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: sum_kernel_tb.sv
/*
 * Testbench for the sum kernel compute unit. Runs a job table through
 * it with the result port always ready, stalled and random, and checks
 * every record and the Wishbone registers.
 */

`timescale 1ns/1ps
`default_nettype none

module sum_kernel_tb;

	localparam int CU_ID           = 3;
	localparam int RESULT_DEPTH    = 4;
	localparam int N_JOBS          = 8;
	localparam int N_EDGES         = 13;
	localparam int N_PASSES        = 3;
	localparam int WATCHDOG_CYCLES = N_PASSES * (N_EDGES + N_JOBS) * 20 + 300;

	typedef struct packed {
		sum_kernel_pkg::vertex_id_t vertex_id;
		sum_kernel_pkg::degree_t    degree;
		logic [7:0]                 start;
	} job_entry_t;

	// vertex id, degree, index of its first edge
	job_entry_t job_table [N_JOBS] = '{
		'{16'h0010, 16'd3, 8'd0},  '{16'h0021, 16'd0, 8'd0},
		'{16'h0032, 16'd2, 8'd3},  '{16'h0043, 16'd1, 8'd5},
		'{16'h0054, 16'd4, 8'd6},  '{16'h0065, 16'd0, 8'd0},
		'{16'h0076, 16'd2, 8'd10}, '{16'h0087, 16'd1, 8'd12}
	};
	// jobs starting at 3, 6 and 10 wrap past 2^32
	sum_kernel_pkg::edge_data_t edge_table [N_EDGES] = '{
		32'h0000_0001, 32'h0000_0002, 32'h0000_0003, 32'hffff_fff0, 32'h0000_0020,
		32'hdead_beef, 32'h8000_0000, 32'h8000_0000, 32'h0000_0005, 32'h1234_5678,
		32'h0000_0100, 32'hffff_ff00, 32'h0000_0007
	};

	logic                       clock = 1'b0;
	logic                       rstn;
	logic                       job_valid;
	sum_kernel_pkg::vertex_id_t job_vertex_id;
	sum_kernel_pkg::degree_t    job_degree;
	logic                       job_ready;
	logic                       edge_valid;
	sum_kernel_pkg::edge_data_t edge_data;
	logic                       edge_ready;
	logic                       result_valid;
	sum_kernel_pkg::vertex_id_t result_vertex_id;
	sum_kernel_pkg::sum_t       result_sum;
	logic                       result_ready = 1'b0;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	sum_kernel_pkg::wb_addr_t   wb_adr;
	sum_kernel_pkg::wb_data_t   wb_wdata;
	sum_kernel_pkg::wb_data_t   wb_rdata;
	logic                       wb_ack;

	sum_kernel_pkg::vertex_result_t expected_q [$];
	sum_kernel_pkg::wb_data_t       read_data;
	integer                         seed = 32'h2979;
	int                             errors = 0;
	int                             received = 0;
	int                             jobs_taken = 0;
	int                             edges_sent = 0;
	// result_ready: 0 low, 1 high, 2 random
	int                             ready_mode = 0;

	sum_kernel_cu #(.CU_ID(CU_ID), .RESULT_DEPTH(RESULT_DEPTH)) sum_kernel_cu_inst (.*);

	bind sum_kernel_cu sum_kernel_checker sum_kernel_checker_inst (
		.clock, .rstn, .wb_cyc, .wb_stb, .wb_ack, .job_ready, .edge_ready,
		.result_valid, .result_ready, .result_vertex_id, .result_sum
	);

	always #5 clock = ~clock;

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic check_result(input sum_kernel_pkg::vertex_result_t expected,
			input sum_kernel_pkg::vertex_result_t actual);
		if (actual !== expected) begin
			$display("ERR result_vertex_id/result_sum expected %h/%h actual %h/%h",
				expected.vertex_id, expected.sum, actual.vertex_id, actual.sum);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input sum_kernel_pkg::wb_data_t expected,
			input sum_kernel_pkg::wb_data_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	////////////////////
	// bus and stream drivers
	////////////////////

	task automatic wb_access(input logic we, input sum_kernel_pkg::wb_addr_t adr,
			input sum_kernel_pkg::wb_data_t wdata, output sum_kernel_pkg::wb_data_t rdata);
		@(negedge clock);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_wdata = wdata;
		// ack is due one clock after the strobe
		@(negedge clock);
		if (!wb_ack) begin
			$display("no Wishbone ack one cycle after the strobe at address %h", adr);
			errors++;
		end
		rdata = wb_rdata;
		// strobe stays up through the edge that samples the ack
		@(negedge clock);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic read_and_check(input sum_kernel_pkg::wb_addr_t adr,
			input sum_kernel_pkg::wb_data_t expected, input string name);
		sum_kernel_pkg::wb_data_t data;
		wb_access(1'b0, adr, '0, data);
		check_word(name, expected, data);
	endtask

	task automatic send_job(input int i);
		@(negedge clock);
		job_valid     = 1'b1;
		job_vertex_id = job_table[i].vertex_id;
		job_degree    = job_table[i].degree;
		while (!job_ready)
			@(negedge clock);
		@(negedge clock);
		job_valid = 1'b0;
		for (int k = 0; k < int'(job_table[i].degree); k++) begin
			edge_valid = 1'b1;
			edge_data  = edge_table[int'(job_table[i].start) + k];
			while (!edge_ready)
				@(negedge clock);
			@(negedge clock);
			edge_valid = 1'b0;
			edges_sent++;
		end
		jobs_taken++;
	endtask

	task automatic run_table();
		sum_kernel_pkg::vertex_result_t rec;
		for (int i = 0; i < N_JOBS; i++) begin
			rec.vertex_id = job_table[i].vertex_id;
			rec.sum       = '0;
			for (int k = 0; k < int'(job_table[i].degree); k++)
				rec.sum = rec.sum + edge_table[int'(job_table[i].start) + k];
			expected_q.push_back(rec);
			send_job(i);
		end
	endtask

	// ready is set here, and a record with valid and ready high now
	// leaves on the next rising edge
	initial forever begin
		@(negedge clock);
		case (ready_mode)
			0:       result_ready = 1'b0;
			1:       result_ready = 1'b1;
			default: result_ready = ($random(seed) & 1) != 0;
		endcase
		if (rstn && result_valid && result_ready) begin
			if (expected_q.size() == 0) begin
				$display("record for vertex %h arrived with none expected", result_vertex_id);
				errors++;
			end else begin
				check_result(expected_q.pop_front(), {result_vertex_id, result_sum});
			end
			received++;
		end
	end

	////////////////////
	// test sequence
	////////////////////

	initial begin
		rstn          = 1'b0;
		job_valid     = 1'b0;
		job_vertex_id = '0;
		job_degree    = '0;
		edge_valid    = 1'b0;
		edge_data     = '0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_wdata      = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// disabled unit must ignore an offered job
		job_valid     = 1'b1;
		job_vertex_id = 16'h00ff;
		job_degree    = 16'd1;
		repeat (6) begin
			@(negedge clock);
			if (job_ready) begin
				$display("job_ready went high while the unit is disabled");
				errors++;
			end
		end
		job_valid = 1'b0;
		read_and_check(sum_kernel_pkg::REG_CTRL, 32'h0, "wb_rdata CTRL");
		read_and_check(sum_kernel_pkg::REG_CU_ID, CU_ID, "wb_rdata CU_ID");
		wb_access(1'b1, sum_kernel_pkg::REG_CTRL, 32'h1 << sum_kernel_pkg::CTRL_ENABLE_BIT,
			read_data);

		ready_mode = 1;
		run_table();
		wait (received == jobs_taken);

		// stalled port, four records in the buffer and one in the accumulator
		ready_mode = 0;
		fork
			run_table();
			begin
				wait (jobs_taken == N_JOBS + RESULT_DEPTH + 1);
				repeat (12) begin
					@(negedge clock);
					if (job_ready) begin
						$display("job_ready went high while the result buffer is full");
						errors++;
					end
				end
				ready_mode = 1;
			end
		join
		wait (received == jobs_taken);

		ready_mode = 2;
		run_table();
		wait (received == jobs_taken);

		read_and_check(sum_kernel_pkg::REG_EDGE_COUNT, sum_kernel_pkg::wb_data_t'(edges_sent),
			"wb_rdata EDGE_COUNT");
		read_and_check(sum_kernel_pkg::REG_VERTEX_COUNT,
			sum_kernel_pkg::wb_data_t'(jobs_taken), "wb_rdata VERTEX_COUNT");
		wb_access(1'b1, sum_kernel_pkg::REG_CTRL, (32'h1 << sum_kernel_pkg::CTRL_ENABLE_BIT) |
			(32'h1 << sum_kernel_pkg::CTRL_CLEAR_BIT), read_data);
		read_and_check(sum_kernel_pkg::REG_EDGE_COUNT, 32'h0, "wb_rdata EDGE_COUNT");
		read_and_check(sum_kernel_pkg::REG_VERTEX_COUNT, 32'h0, "wb_rdata VERTEX_COUNT");
		read_and_check(sum_kernel_pkg::REG_CTRL, 32'h1, "wb_rdata CTRL");

		errors += sum_kernel_cu_inst.sum_kernel_checker_inst.failures;
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sum_kernel_checker.sv
/*
 * Handshake assertions for the sum kernel compute unit.
 * Bound to the top level from the testbench.
 */

`timescale 1ns/1ps
`default_nettype none

module sum_kernel_checker (
	input logic                       clock,
	input logic                       rstn,
	input logic                       wb_cyc,
	input logic                       wb_stb,
	input logic                       wb_ack,
	input logic                       job_ready,
	input logic                       edge_ready,
	input logic                       result_valid,
	input logic                       result_ready,
	input sum_kernel_pkg::vertex_id_t result_vertex_id,
	input sum_kernel_pkg::sum_t       result_sum
);

	// number of failed assertions so far
	int failures = 0;

	ack_needs_strobe: assert property (@(posedge clock) disable iff (!rstn)
		wb_ack |-> (wb_cyc && wb_stb))
		else begin
			failures++;
			$error("wb_ack without an active strobe");
		end

	ack_single_cycle: assert property (@(posedge clock) disable iff (!rstn)
		wb_ack |=> !wb_ack)
		else begin
			failures++;
			$error("wb_ack high for two cycles in a row");
		end

	// a stalled record must not move or change
	result_held: assert property (@(posedge clock) disable iff (!rstn)
		(result_valid && !result_ready) |=>
			(result_valid && $stable(result_vertex_id) && $stable(result_sum)))
		else begin
			failures++;
			$error("result changed while stalled");
		end

	job_edge_exclusive: assert property (@(posedge clock) disable iff (!rstn)
		!(job_ready && edge_ready))
		else begin
			failures++;
			$error("job_ready and edge_ready both high");
		end

endmodule

`default_nettype wire

// File: sum_kernel_cu.sv
/*
 * Top level of the sum kernel compute unit.
 * Vertex jobs and edge values come in on valid/ready ports, result
 * records leave through a write buffer, and a Wishbone classic port
 * reaches the control and counter registers.
 */

`timescale 1ns/1ps
`default_nettype none

module sum_kernel_cu #(
	parameter int CU_ID        = 1,
	parameter int RESULT_DEPTH = 4
) (
	input  logic                        clock,
	input  logic                        rstn,
	// vertex jobs
	input  logic                        job_valid,
	input  sum_kernel_pkg::vertex_id_t  job_vertex_id,
	input  sum_kernel_pkg::degree_t     job_degree,
	output logic                        job_ready,
	// edge stream
	input  logic                        edge_valid,
	input  sum_kernel_pkg::edge_data_t  edge_data,
	output logic                        edge_ready,
	// result records
	output logic                        result_valid,
	output sum_kernel_pkg::vertex_id_t  result_vertex_id,
	output sum_kernel_pkg::sum_t        result_sum,
	input  logic                        result_ready,
	// Wishbone classic
	input  logic                        wb_cyc,
	input  logic                        wb_stb,
	input  logic                        wb_we,
	input  sum_kernel_pkg::wb_addr_t    wb_adr,
	input  sum_kernel_pkg::wb_data_t    wb_wdata,
	output sum_kernel_pkg::wb_data_t    wb_rdata,
	output logic                        wb_ack
);

	logic enable;
	logic edge_taken;
	logic vertex_done;

	result_stream_if #(.payload_t(sum_kernel_pkg::vertex_result_t)) push_if ();
	result_stream_if #(.payload_t(sum_kernel_pkg::vertex_result_t)) pop_if ();

	// pop side unpacked onto the plain result ports
	assign pop_if.ready     = result_ready;
	assign result_valid     = pop_if.valid;
	assign result_vertex_id = pop_if.payload.vertex_id;
	assign result_sum       = pop_if.payload.sum;

	vertex_sum_accumulator vertex_sum_accumulator_inst (
		.clock         (clock),
		.rstn          (rstn),
		.enable        (enable),
		.job_valid     (job_valid),
		.job_vertex_id (job_vertex_id),
		.job_degree    (job_degree),
		.job_ready     (job_ready),
		.edge_valid    (edge_valid),
		.edge_data     (edge_data),
		.edge_ready    (edge_ready),
		.result        (push_if.source),
		.edge_taken    (edge_taken),
		.vertex_done   (vertex_done)
	);

	sync_fifo #(
		.item_t (sum_kernel_pkg::vertex_result_t),
		.DEPTH  (RESULT_DEPTH)
	) result_buffer_inst (
		.clock     (clock),
		.rstn      (rstn),
		.push_side (push_if.sink),
		.pop_side  (pop_if.source)
	);

	sum_kernel_regs #(
		.CU_ID (CU_ID)
	) sum_kernel_regs_inst (
		.clock       (clock),
		.rstn        (rstn),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_wdata    (wb_wdata),
		.wb_rdata    (wb_rdata),
		.wb_ack      (wb_ack),
		.edge_taken  (edge_taken),
		.vertex_done (vertex_done),
		.enable      (enable)
	);

endmodule

`default_nettype wire

// File: sum_kernel_regs.sv
/*
 * Wishbone classic register block of the compute unit.
 * Holds the enable bit, counts accepted edges and finished vertices
 * and reports the unit id. Ack follows the strobe by one clock.
 */

`timescale 1ns/1ps
`default_nettype none

module sum_kernel_regs #(
	parameter int CU_ID = 1
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  sum_kernel_pkg::wb_addr_t  wb_adr,
	input  sum_kernel_pkg::wb_data_t  wb_wdata,
	output sum_kernel_pkg::wb_data_t  wb_rdata,
	output logic                      wb_ack,
	input  logic                      edge_taken,
	input  logic                      vertex_done,
	output logic                      enable
);

	sum_kernel_pkg::wb_data_t edge_count;
	sum_kernel_pkg::wb_data_t vertex_count;
	sum_kernel_pkg::wb_data_t read_word;
	logic                     access;
	logic                     ctrl_write;
	logic                     clear;

	// a new access is the first strobe cycle, not the one carrying the ack
	assign access     = wb_cyc && wb_stb && !wb_ack;
	assign ctrl_write = access && wb_we && (wb_adr == sum_kernel_pkg::REG_CTRL);
	assign clear      = ctrl_write && wb_wdata[sum_kernel_pkg::CTRL_CLEAR_BIT];

	////////////////////
	// read mux
	////////////////////

	always_comb begin
		read_word = '0;
		case (wb_adr)
			sum_kernel_pkg::REG_CTRL:         read_word[sum_kernel_pkg::CTRL_ENABLE_BIT] = enable;
			sum_kernel_pkg::REG_EDGE_COUNT:   read_word = edge_count;
			sum_kernel_pkg::REG_VERTEX_COUNT: read_word = vertex_count;
			sum_kernel_pkg::REG_CU_ID:        read_word = sum_kernel_pkg::wb_data_t'(CU_ID);
			default:                          read_word = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wb_ack   <= 1'b0;
			wb_rdata <= '0;
			enable   <= 1'b0;
		end else begin
			wb_ack <= access;
			if (access && !wb_we)
				wb_rdata <= read_word;
			if (ctrl_write)
				enable <= wb_wdata[sum_kernel_pkg::CTRL_ENABLE_BIT];
		end
	end

	////////////////////
	// counters
	////////////////////

	// clear wins over a pulse in the same cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count   <= '0;
			vertex_count <= '0;
		end else if (clear) begin
			edge_count   <= '0;
			vertex_count <= '0;
		end else begin
			if (edge_taken)
				edge_count <= edge_count + 1'b1;
			if (vertex_done)
				vertex_count <= vertex_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: vertex_sum_accumulator.sv
/*
 * Takes one vertex job at a time, accepts as many edge values as its
 * out-degree and adds them into a wrapping 32-bit sum. The finished
 * record is offered on the result stream until the write buffer takes it.
 */

`timescale 1ns/1ps
`default_nettype none

module vertex_sum_accumulator (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enable,
	input  logic                        job_valid,
	input  sum_kernel_pkg::vertex_id_t  job_vertex_id,
	input  sum_kernel_pkg::degree_t     job_degree,
	output logic                        job_ready,
	input  logic                        edge_valid,
	input  sum_kernel_pkg::edge_data_t  edge_data,
	output logic                        edge_ready,
	result_stream_if.source             result,
	output logic                        edge_taken,
	output logic                        vertex_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SUMMING,
		ST_EMITTING
	} state_t;

	state_t                     state;
	sum_kernel_pkg::vertex_id_t vertex_id_q;
	sum_kernel_pkg::degree_t    degree_q;
	sum_kernel_pkg::degree_t    edge_count;
	sum_kernel_pkg::sum_t       sum_q;
	logic                       job_fire;
	logic                       edge_fire;
	logic                       push_fire;

	////////////////////
	// handshakes
	////////////////////

	// disabling only blocks the next job, a running one finishes
	assign job_ready  = enable && (state == ST_IDLE);
	assign edge_ready = (state == ST_SUMMING);

	assign job_fire  = job_valid && job_ready;
	assign edge_fire = edge_valid && edge_ready;
	assign push_fire = result.valid && result.ready;

	assign edge_taken  = edge_fire;
	assign vertex_done = push_fire;

	assign result.valid             = (state == ST_EMITTING);
	assign result.payload.vertex_id = vertex_id_q;
	assign result.payload.sum       = sum_q;

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= ST_IDLE;
			edge_count <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (job_fire) begin
						edge_count <= '0;
						// zero degree goes straight to the push
						state <= (job_degree == '0) ? ST_EMITTING : ST_SUMMING;
					end
				end
				ST_SUMMING: begin
					if (edge_fire) begin
						edge_count <= edge_count + 1'b1;
						if (edge_count + 1'b1 == degree_q)
							state <= ST_EMITTING;
					end
				end
				ST_EMITTING: begin
					// held here while the buffer is full
					if (push_fire)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// job fields and running sum
	always_ff @(posedge clock) begin
		if (job_fire) begin
			vertex_id_q <= job_vertex_id;
			degree_q    <= job_degree;
			sum_q       <= '0;
		end else if (edge_fire) begin
			sum_q <= sum_q + edge_data;
		end
	end

endmodule

`default_nettype wire

// File: sync_fifo.sv
/*
 * First-word-fall-through buffer between two valid/ready streams.
 * The head item sits in a registered read slot, the rest wait in a
 * circular store of DEPTH-1 entries. Total capacity is DEPTH (at least 2).
 */

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type item_t = logic,
	parameter int  DEPTH  = 4
) (
	input  logic                 clock,
	input  logic                 rstn,
	result_stream_if.sink   push_side,
	result_stream_if.source pop_side
);

	localparam int MEM_DEPTH = DEPTH - 1;
	localparam int PTR_W     = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
	localparam int CNT_W     = $clog2(DEPTH);

	item_t            mem [MEM_DEPTH];
	item_t            slot_data;
	logic             slot_valid;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] mem_count;
	logic             push;
	logic             pop;
	logic             mem_empty;
	logic             slot_take_push;
	logic             mem_write;
	logic             mem_read;

	assign mem_empty = (mem_count == '0);
	assign push_side.ready = !(slot_valid && (mem_count == CNT_W'(MEM_DEPTH)));
	assign pop_side.valid = slot_valid;
	assign pop_side.payload = slot_data;

	assign push = push_side.valid && push_side.ready;
	assign pop  = pop_side.valid && pop_side.ready;

	// new item goes straight to the slot when nothing is queued ahead of it
	assign slot_take_push = push && (!slot_valid || (pop && mem_empty));
	assign mem_write      = push && !slot_take_push;
	assign mem_read       = pop && !mem_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_valid <= 1'b0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			mem_count  <= '0;
		end else begin
			if (slot_take_push || mem_read)
				slot_valid <= 1'b1;
			else if (pop)
				slot_valid <= 1'b0;
			if (mem_write)
				wr_ptr <= (wr_ptr == PTR_W'(MEM_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (mem_read)
				rd_ptr <= (rd_ptr == PTR_W'(MEM_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			mem_count <= mem_count + CNT_W'(mem_write) - CNT_W'(mem_read);
		end
	end

	// storage and slot payload
	always_ff @(posedge clock) begin
		if (mem_write)
			mem[wr_ptr] <= push_side.payload;
		if (mem_read)
			slot_data <= mem[rd_ptr];
		else if (slot_take_push)
			slot_data <= push_side.payload;
	end

endmodule

`default_nettype wire

// File: result_stream_if.sv
/*
 * Valid/ready stream carrying one payload item per transfer.
 * The source drives valid and payload, the sink drives ready.
 * An item moves on a clock edge where valid and ready are both high.
 */

`timescale 1ns/1ps
`default_nettype none

interface result_stream_if #(
	parameter type payload_t = logic
) ();

	logic     valid;
	logic     ready;
	payload_t payload;

	modport source (
		output valid,
		output payload,
		input  ready
	);

	modport sink (
		input  valid,
		input  payload,
		output ready
	);

endinterface

`default_nettype wire

// File: sum_kernel_pkg.sv
/*
 * Shared types and constants for the sum kernel compute unit.
 * Holds the vertex, edge and sum widths, the result record and the
 * register map of the Wishbone block. Files refer to it by scoped name.
 */

`default_nettype none

package sum_kernel_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int VERTEX_ID_W = 16;
	localparam int DEGREE_W    = 16;
	localparam int EDGE_DATA_W = 32;
	localparam int SUM_W       = 32;
	localparam int WB_ADDR_W   = 4;
	localparam int WB_DATA_W   = 32;

	typedef logic [VERTEX_ID_W-1:0] vertex_id_t;
	typedef logic [DEGREE_W-1:0]    degree_t;
	typedef logic [EDGE_DATA_W-1:0] edge_data_t;
	// wraps modulo 2^32
	typedef logic [SUM_W-1:0]       sum_t;

	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;

	// one record per finished vertex, vertex id in the upper bits
	typedef struct packed {
		vertex_id_t vertex_id;
		sum_t       sum;
	} vertex_result_t;

	////////////////////
	// register map
	////////////////////

	localparam wb_addr_t REG_CTRL         = 4'h0;
	localparam wb_addr_t REG_EDGE_COUNT   = 4'h4;
	localparam wb_addr_t REG_VERTEX_COUNT = 4'h8;
	localparam wb_addr_t REG_CU_ID        = 4'hC;

	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_CLEAR_BIT  = 1;

endpackage

`default_nettype wire
